// File: hdl/SdramPkg.sv
////////////////////////////////////////
// SDRAM device definitions: command encoding,
// address and bank widths, mode register word
////////////////////////////////////////

package SdramPkg;

	localparam int SdramAddrWidth = 13;                 // row address A12..A0
	localparam int SdramBankWidth = 2;                  // BA1..BA0, four banks

	typedef logic [4:0]                sdramCmd_t;      // {CKE, CS_L, RAS_L, CAS_L, WE_L}
	typedef logic [SdramAddrWidth-1:0] sdramAddr_t;     // address pins
	typedef logic [SdramBankWidth-1:0] sdramBank_t;     // bank select pins

	////////////////////////////////////////
	// commands, bit order CKE CS RAS CAS WE
	////////////////////////////////////////

	localparam sdramCmd_t CmdPowerUp     = 5'b00000;    // CKE and CS held low during power-up
	localparam sdramCmd_t CmdNop         = 5'b10111;    // no operation
	localparam sdramCmd_t CmdPrecharge   = 5'b10010;    // precharge, A10 selects all banks
	localparam sdramCmd_t CmdAutoRefresh = 5'b10001;    // CBR auto-refresh
	localparam sdramCmd_t CmdModeSet     = 5'b10000;    // load mode register from address pins

	// address bit that turns a precharge into precharge-all
	localparam int PrechargeAllBit = 10;

	////////////////////////////////////////
	// mode register fields
	////////////////////////////////////////

	localparam logic [2:0] ModeBurstLength1   = 3'b000; // A2..A0, single word bursts
	localparam logic       ModeBurstSequence  = 1'b0;   // A3, sequential order
	localparam logic [2:0] ModeCasLatency2    = 3'b010; // A6..A4, CL = 2
	localparam logic [1:0] ModeOperatingStd   = 2'b00;  // A8..A7, standard operation
	localparam logic       ModeWriteBurstProg = 1'b0;   // A9, writes follow burst length
	localparam logic [2:0] ModeReservedBits   = 3'b000; // A12..A10 must be zero

	// full word placed on the address pins during the mode set command
	localparam sdramAddr_t ModeRegValue = {
		ModeReservedBits,                               // A12..A10
		ModeWriteBurstProg,                             // A9
		ModeOperatingStd,                               // A8..A7
		ModeCasLatency2,                                // A6..A4
		ModeBurstSequence,                              // A3
		ModeBurstLength1                                // A2..A0
	};

endpackage

// File: hdl/CtrlPkg.sv
////////////////////////////////////////
// controller definitions: cycle count type and
// the init/refresh sequencer state encoding
////////////////////////////////////////

package CtrlPkg;

	localparam int CycleCountWidth = 16;                // timers and gap counter share this width

	typedef logic [CycleCountWidth-1:0] cycleCount_t;   // clock cycle counts

	////////////////////////////////////////
	// sequencer states
	////////////////////////////////////////

	typedef enum logic [3:0] {
		InitState     = 4'd0,                           // load power-up timer
		WaitPowerUp   = 4'd1,                           // CKE low until timer expires
		FirstNop      = 4'd2,                           // first command with CKE high
		InitPrecharge = 4'd3,                           // precharge all banks
		InitNop       = 4'd4,                           // one NOP before the refresh burst
		InitRefresh   = 4'd5,                           // one of the init auto-refreshes
		InitGap       = 4'd6,                           // NOPs after each init refresh
		ModeSet       = 4'd7,                           // program the mode register
		ModeGap       = 4'd8,                           // NOPs after mode set
		Idle          = 4'd9,                           // CPU running, wait for refresh timer
		RefPrecharge  = 4'd10,                          // periodic refresh, precharge all
		RefNop        = 4'd11,                          // one NOP before the refresh
		RefRefresh    = 4'd12,                          // periodic auto-refresh
		RefGap        = 4'd13                           // NOPs after periodic refresh
	} seqState_t;

endpackage

// File: hdl/DownTimer.sv
////////////////////////////////////////
// loadable down-counter with a done level
////////////////////////////////////////

`timescale 1ns/1ps

module DownTimer
#(
	parameter CtrlPkg::cycleCount_t Count = 16'd1       // preset taken on Load
)
(
	input  logic Clock,
	input  logic Reset_L,
	input  logic Load,                                  // one-cycle preset request
	output logic Done                                   // high while the count sits at zero
);

	import CtrlPkg::*;

	cycleCount_t count;                                 // remaining cycles

	// preset wins over counting, count parks at zero
	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
			count <= '0;                                // expired after reset
		else if (Load)
			count <= Count;
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign Done = (count == '0);                        // level, not a pulse

endmodule

// File: hdl/InitRefreshSequencer.sv
////////////////////////////////////////
// SDRAM init and auto-refresh sequencer FSM,
// registered device pins and CPU reset release
////////////////////////////////////////

`timescale 1ns/1ps

module InitRefreshSequencer
#(
	parameter CtrlPkg::cycleCount_t InitRefreshCount = 16'd8,  // refreshes during init
	parameter CtrlPkg::cycleCount_t GapCycles        = 16'd3,  // NOPs after each refresh
	parameter CtrlPkg::cycleCount_t ModeGapCycles    = 16'd3   // NOPs after mode set
)
(
	input  logic                 Clock,
	input  logic                 Reset_L,
	input  logic                 PowerUpDone,        // power-up timer expired
	input  logic                 RefreshDue,         // refresh interval timer expired
	output logic                 PowerUpLoad,        // preset power-up timer
	output logic                 RefreshLoad,        // preset refresh timer
	output logic                 SdramCke,
	output logic                 SdramCs_L,
	output logic                 SdramRas_L,
	output logic                 SdramCas_L,
	output logic                 SdramWe_L,
	output SdramPkg::sdramAddr_t SdramAddr,
	output SdramPkg::sdramBank_t SdramBa,
	output logic                 ResetOut_L          // CPU held in reset until init completes
);

	import SdramPkg::*;
	import CtrlPkg::*;

	seqState_t   state;                              // current state
	seqState_t   nextState;
	cycleCount_t gapCount;                           // NOPs left in the current gap, minus one
	cycleCount_t gapNext;
	cycleCount_t refreshCount;                       // init refreshes issued so far
	cycleCount_t refreshNext;
	logic        gapLast;                            // final NOP of a gap

	sdramCmd_t   cmdNext;                            // command for the next pin cycle
	sdramAddr_t  addrNext;
	logic        cpuRunNext;                         // release CPU reset next cycle

	assign gapLast = (gapCount == '0);

	////////////////////////////////////////
	// state and counter registers
	////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state        <= InitState;
			gapCount     <= '0;
			refreshCount <= '0;
		end
		else
		begin
			state        <= nextState;
			gapCount     <= gapNext;
			refreshCount <= refreshNext;
		end
	end

	////////////////////////////////////////
	// next state, command and address
	////////////////////////////////////////

	always_comb
	begin
		nextState   = state;
		gapNext     = gapCount;
		refreshNext = refreshCount;
		cmdNext     = CmdNop;                        // NOP unless a state says otherwise
		addrNext    = '0;
		cpuRunNext  = 1'b0;

		case (state)
			InitState:
			begin
				cmdNext     = CmdPowerUp;
				refreshNext = '0;                    // fresh init refresh tally
				nextState   = WaitPowerUp;
			end

			WaitPowerUp:
			begin
				cmdNext = CmdPowerUp;                // CKE and CS stay low
				if (PowerUpDone)
					nextState = FirstNop;
			end

			FirstNop:
				nextState = InitPrecharge;           // device leaves power-down on this NOP

			InitPrecharge:
			begin
				cmdNext                  = CmdPrecharge;
				addrNext[PrechargeAllBit] = 1'b1;    // all banks
				nextState                = InitNop;
			end

			InitNop:
				nextState = InitRefresh;

			InitRefresh:
			begin
				cmdNext     = CmdAutoRefresh;
				refreshNext = refreshCount + 1'b1;
				gapNext     = GapCycles - 1'b1;      // gap counts down to zero
				nextState   = InitGap;
			end

			InitGap:
			begin
				if (!gapLast)
					gapNext = gapCount - 1'b1;
				else if (refreshCount == InitRefreshCount)
					nextState = ModeSet;             // burst of refreshes finished
				else
					nextState = InitRefresh;
			end

			ModeSet:
			begin
				cmdNext   = CmdModeSet;
				addrNext  = ModeRegValue;            // BL1, sequential, CL2
				gapNext   = ModeGapCycles - 1'b1;
				nextState = ModeGap;
			end

			ModeGap:
			begin
				if (!gapLast)
					gapNext = gapCount - 1'b1;
				else
					nextState = Idle;                // refresh timer preset this cycle
			end

			Idle:
			begin
				cpuRunNext = 1'b1;
				if (RefreshDue)
					nextState = RefPrecharge;
			end

			RefPrecharge:
			begin
				cpuRunNext                = 1'b1;
				cmdNext                   = CmdPrecharge;
				addrNext[PrechargeAllBit] = 1'b1;
				nextState                 = RefNop;
			end

			RefNop:
			begin
				cpuRunNext = 1'b1;
				nextState  = RefRefresh;
			end

			RefRefresh:
			begin
				cpuRunNext = 1'b1;
				cmdNext    = CmdAutoRefresh;
				gapNext    = GapCycles - 1'b1;
				nextState  = RefGap;
			end

			RefGap:
			begin
				cpuRunNext = 1'b1;
				if (!gapLast)
					gapNext = gapCount - 1'b1;
				else
					nextState = Idle;
			end

			default:
				nextState = InitState;               // unused encodings restart init
		endcase
	end

	// timer presets, one cycle each
	assign PowerUpLoad = (state == InitState);
	assign RefreshLoad = ((state == ModeGap) || (state == RefGap)) && gapLast;

	////////////////////////////////////////
	// registered device and CPU pins
	////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			{SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L} <= CmdPowerUp;
			SdramAddr  <= '0;
			SdramBa    <= '0;
			ResetOut_L <= 1'b0;                      // CPU held in reset
		end
		else
		begin
			{SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L} <= cmdNext;
			SdramAddr  <= addrNext;
			SdramBa    <= '0;                        // all commands here use bank 0
			ResetOut_L <= cpuRunNext;                // high from first Idle output cycle
		end
	end

endmodule

// File: hdl/SdramInitRefreshCtrl.sv
////////////////////////////////////////
// SDRAM init/refresh controller top level
////////////////////////////////////////

`timescale 1ns/1ps

module SdramInitRefreshCtrl
#(
	parameter CtrlPkg::cycleCount_t PowerUpCycles    = 16'd5000, // 100 us at 50 MHz
	parameter CtrlPkg::cycleCount_t RefreshInterval  = 16'd375,  // idle clocks between refreshes
	parameter CtrlPkg::cycleCount_t InitRefreshCount = 16'd8,
	parameter CtrlPkg::cycleCount_t GapCycles        = 16'd3,
	parameter CtrlPkg::cycleCount_t ModeGapCycles    = 16'd3
)
(
	input  logic                 Clock,
	input  logic                 Reset_L,
	output logic                 SdramCke,
	output logic                 SdramCs_L,
	output logic                 SdramRas_L,
	output logic                 SdramCas_L,
	output logic                 SdramWe_L,
	output SdramPkg::sdramAddr_t SdramAddr,
	output SdramPkg::sdramBank_t SdramBa,
	output logic                 ResetOut_L
);

	logic PowerUpLoad;                                // sequencer to power-up timer
	logic PowerUpDone;
	logic RefreshLoad;                                // sequencer to refresh timer
	logic RefreshDue;

	DownTimer #(.Count(PowerUpCycles)) powerUpTimer0 (
		.Clock   (Clock),
		.Reset_L (Reset_L),
		.Load    (PowerUpLoad),
		.Done    (PowerUpDone)
	);

	DownTimer #(.Count(RefreshInterval)) refreshTimer0 (
		.Clock   (Clock),
		.Reset_L (Reset_L),
		.Load    (RefreshLoad),
		.Done    (RefreshDue)
	);

	InitRefreshSequencer #(
		.InitRefreshCount (InitRefreshCount),
		.GapCycles        (GapCycles),
		.ModeGapCycles    (ModeGapCycles)
	) seq0 (
		.Clock       (Clock),
		.Reset_L     (Reset_L),
		.PowerUpDone (PowerUpDone),
		.RefreshDue  (RefreshDue),
		.PowerUpLoad (PowerUpLoad),
		.RefreshLoad (RefreshLoad),
		.SdramCke    (SdramCke),
		.SdramCs_L   (SdramCs_L),
		.SdramRas_L  (SdramRas_L),
		.SdramCas_L  (SdramCas_L),
		.SdramWe_L   (SdramWe_L),
		.SdramAddr   (SdramAddr),
		.SdramBa     (SdramBa),
		.ResetOut_L  (ResetOut_L)
	);

endmodule

// File: sim/SdramCtrl_asserts.sv
////////////////////////////////////////
// bound checker for the SDRAM controller pins:
// init order, refresh spacing, CPU reset release
////////////////////////////////////////

`timescale 1ns/1ps

module SdramCtrlAsserts
#(
	parameter CtrlPkg::cycleCount_t PowerUpCycles    = 16'd5000,
	parameter CtrlPkg::cycleCount_t RefreshInterval  = 16'd375,
	parameter CtrlPkg::cycleCount_t InitRefreshCount = 16'd8,
	parameter CtrlPkg::cycleCount_t GapCycles        = 16'd3,
	parameter CtrlPkg::cycleCount_t ModeGapCycles    = 16'd3
)
(
	input logic                 Clock,
	input logic                 Reset_L,
	input logic                 SdramCke,
	input logic                 SdramCs_L,
	input logic                 SdramRas_L,
	input logic                 SdramCas_L,
	input logic                 SdramWe_L,
	input SdramPkg::sdramAddr_t SdramAddr,
	input SdramPkg::sdramBank_t SdramBa,
	input logic                 ResetOut_L
);

	import SdramPkg::*;
	import CtrlPkg::*;

	localparam sdramAddr_t AllBanksAddr = sdramAddr_t'(1) << PrechargeAllBit;
	localparam int RefreshPeriod = RefreshInterval + GapCycles + 4;   // refresh to refresh

	sdramCmd_t cmd;                                  // pins packed as a command
	int        failCount;                            // failed checks so far
	int        ckeLowRun;                            // cycles with CKE low since reset
	int        refreshTally;                         // refreshes since last precharge
	int        nopTally;                             // NOPs since last refresh
	int        sinceRefresh;                         // cycles since last refresh
	logic      inGap;                                // NOP run after a refresh
	logic      periodicSeen;                         // a refresh with CPU running seen

	assign cmd = {SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L};

	initial
		failCount = 0;

	task automatic noteFailure(input string what);
		failCount++;
		$error("%s", what);
	endtask

	////////////////////////////////////////
	// pin history
	////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			ckeLowRun    <= 0;
			refreshTally <= 0;
			nopTally     <= 0;
			sinceRefresh <= 0;
			inGap        <= 1'b0;
			periodicSeen <= 1'b0;
		end
		else
		begin
			ckeLowRun    <= SdramCke ? 0 : ckeLowRun + 1;
			sinceRefresh <= (cmd == CmdAutoRefresh) ? 1 : sinceRefresh + 1;
			if (cmd == CmdAutoRefresh)
			begin
				refreshTally <= refreshTally + 1;
				nopTally     <= 0;
				inGap        <= 1'b1;
				periodicSeen <= periodicSeen | ResetOut_L;
			end
			else if (cmd == CmdNop)
				nopTally <= nopTally + 1;
			else
			begin
				inGap <= 1'b0;                           // gap ended by another command
				if (cmd == CmdPrecharge)
					refreshTally <= 0;
			end
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	aResetPins: assert property (@(posedge Clock) (!Reset_L && $past(!Reset_L)) |->
		cmd == CmdPowerUp && SdramAddr == '0 && SdramBa == '0 && !ResetOut_L)
		else noteFailure("pins not at post-reset values while reset is low");

	aPowerUpHold: assert property (@(posedge Clock) disable iff (!Reset_L)
		!SdramCke |-> cmd == CmdPowerUp && !ResetOut_L)
		else noteFailure("CKE low but command or CPU reset not in power-up state");

	aFirstNop: assert property (@(posedge Clock) disable iff (!Reset_L)
		$rose(SdramCke) |-> cmd == CmdNop && ckeLowRun >= PowerUpCycles)
		else noteFailure("first CKE-high command not a NOP or power-up wait too short");

	aFirstPrecharge: assert property (@(posedge Clock) disable iff (!Reset_L)
		($past(SdramCke) && !$past(SdramCke, 2)) |-> cmd == CmdPrecharge)
		else noteFailure("first NOP not followed by a precharge");

	aPinAddress: assert property (@(posedge Clock) disable iff (!Reset_L)
		cmd != CmdModeSet |->
		SdramBa == '0 && SdramAddr == ((cmd == CmdPrecharge) ? AllBanksAddr : '0))
		else noteFailure("address or bank pins wrong for the command");

	aInitGap: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!ResetOut_L && inGap && (cmd == CmdAutoRefresh || cmd == CmdModeSet)) |->
		nopTally == GapCycles)
		else noteFailure("init refresh not followed by the right number of NOPs");

	aModeSet: assert property (@(posedge Clock) disable iff (!Reset_L)
		cmd == CmdModeSet |->
		refreshTally == InitRefreshCount && SdramAddr == ModeRegValue && SdramBa == '0)
		else noteFailure("mode set with wrong refresh count, mode word or bank");

	aCpuRelease: assert property (@(posedge Clock) disable iff (!Reset_L)
		$rose(ResetOut_L) |-> $past(cmd == CmdModeSet, ModeGapCycles + 1))
		else noteFailure("CPU reset released at the wrong distance from mode set");

	aCpuHold: assert property (@(posedge Clock) disable iff (!Reset_L)
		!$fell(ResetOut_L))
		else noteFailure("CPU reset dropped without a controller reset");

	aRefreshLeadIn: assert property (@(posedge Clock) disable iff (!Reset_L)
		(ResetOut_L && cmd == CmdAutoRefresh) |-> $past(cmd) == CmdNop &&
		$past(cmd, 2) == CmdPrecharge && $past(SdramAddr, 2) == AllBanksAddr)
		else noteFailure("periodic refresh not led by precharge-all and NOP");

	aRefreshSpacing: assert property (@(posedge Clock) disable iff (!Reset_L)
		(ResetOut_L && cmd == CmdAutoRefresh && periodicSeen) |->
		sinceRefresh == RefreshPeriod)
		else noteFailure("periodic refreshes not evenly spaced");

endmodule

// File: sim/TbSdramCtrl.sv
////////////////////////////////////////
// testbench for the SDRAM init/refresh controller:
// clock, reset, watchdog, stimulus, error count
////////////////////////////////////////

`timescale 1ns/1ps

module TbSdramCtrl;

	import SdramPkg::*;
	import CtrlPkg::*;

	localparam cycleCount_t PowerUpCycles    = 16'd20;
	localparam cycleCount_t RefreshInterval  = 16'd60;
	localparam cycleCount_t InitRefreshCount = 16'd8;
	localparam cycleCount_t GapCycles        = 16'd3;
	localparam cycleCount_t ModeGapCycles    = 16'd3;

	localparam int          ClockPeriod   = 20;      // ns
	localparam int          DriveDelay    = 2;       // ns after the rising edge
	localparam int          ResetCycles   = 4;
	localparam int          RefreshRuns   = 5;       // periodic refreshes before mid-run reset
	localparam logic [31:0] Seed          = 32'h6208_b84a;
	localparam int          RefreshPeriod = RefreshInterval + GapCycles + 4;
	// init states, power-up wait and gaps, plus one cycle of pin register
	localparam int InitCycles = PowerUpCycles + InitRefreshCount * (GapCycles + 1)
		+ ModeGapCycles + 6;
	localparam int ReleaseSlack   = 3;               // release edge and negedge sampling
	localparam int WatchdogCycles = 2 * (2 * (InitCycles + ResetCycles)
		+ (2 * RefreshRuns + 4) * RefreshPeriod);

	logic                 Clock;
	logic                 Reset_L;
	logic                 SdramCke;
	logic                 SdramCs_L;
	logic                 SdramRas_L;
	logic                 SdramCas_L;
	logic                 SdramWe_L;
	sdramAddr_t           SdramAddr;
	sdramBank_t           SdramBa;
	logic                 ResetOut_L;
	sdramCmd_t            cmdPins;                   // pins packed as a command
	int                   valueErrors = 0;
	int                   assertErrors = 0;

	assign cmdPins = {SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L};

	always #(ClockPeriod / 2) Clock = ~Clock;

	SdramInitRefreshCtrl #(
		.PowerUpCycles    (PowerUpCycles),
		.RefreshInterval  (RefreshInterval),
		.InitRefreshCount (InitRefreshCount),
		.GapCycles        (GapCycles),
		.ModeGapCycles    (ModeGapCycles)
	) dut0 (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.SdramCke   (SdramCke),
		.SdramCs_L  (SdramCs_L),
		.SdramRas_L (SdramRas_L),
		.SdramCas_L (SdramCas_L),
		.SdramWe_L  (SdramWe_L),
		.SdramAddr  (SdramAddr),
		.SdramBa    (SdramBa),
		.ResetOut_L (ResetOut_L)
	);

	bind SdramInitRefreshCtrl SdramCtrlAsserts #(
		.PowerUpCycles    (PowerUpCycles),
		.RefreshInterval  (RefreshInterval),
		.InitRefreshCount (InitRefreshCount),
		.GapCycles        (GapCycles),
		.ModeGapCycles    (ModeGapCycles)
	) asserts0 (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.SdramCke   (SdramCke),
		.SdramCs_L  (SdramCs_L),
		.SdramRas_L (SdramRas_L),
		.SdramCas_L (SdramCas_L),
		.SdramWe_L  (SdramWe_L),
		.SdramAddr  (SdramAddr),
		.SdramBa    (SdramBa),
		.ResetOut_L (ResetOut_L)
	);

	////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////

	task automatic expectResetPins();
		if (cmdPins !== CmdPowerUp || SdramAddr !== '0 || SdramBa !== '0 || ResetOut_L !== 1'b0)
		begin
			valueErrors++;
			$display("mismatch at %0t: pins not at reset values, cmd %b addr %h ba %h cpu %b",
				$time, cmdPins, SdramAddr, SdramBa, ResetOut_L);
		end
	endtask

	// caller is a drive delay past a rising edge
	task automatic holdReset(input int cycles);
		Reset_L = 1'b0;
		repeat (cycles)
		begin
			@(negedge Clock);
			expectResetPins();                           // async reset already applied
		end
		@(posedge Clock);
		#DriveDelay Reset_L = 1'b1;
	endtask

	task automatic awaitCpuRelease();
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge Clock);
			cycles++;
		end
		while (ResetOut_L !== 1'b1);
		if (cycles < InitCycles - ReleaseSlack || cycles > InitCycles + ReleaseSlack)
		begin
			valueErrors++;
			$display("mismatch at %0t: CPU reset released after %0d cycles, expected %0d",
				$time, cycles, InitCycles);
		end
	endtask

	task automatic awaitRefreshes(input int count);
		int seen;
		seen = 0;
		while (seen < count)
		begin
			@(negedge Clock);
			if (ResetOut_L === 1'b1 && cmdPins === CmdAutoRefresh)
				seen++;
		end
	endtask

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////

	initial
	begin
		int waitCycles;
		Clock     = 1'b0;
		Reset_L   = 1'b0;
		void'($urandom(Seed));                           // seeds the generator for the run
		holdReset(ResetCycles);
		awaitCpuRelease();
		awaitRefreshes(RefreshRuns);
		waitCycles = $urandom_range(RefreshPeriod, 1);   // reset lands anywhere in a period
		repeat (waitCycles) @(posedge Clock);
		#DriveDelay;
		holdReset(ResetCycles);
		awaitCpuRelease();                               // full init again
		awaitRefreshes(2);
		assertErrors = dut0.asserts0.failCount;
		$display("checks done: %0d assertion failures, %0d value mismatches",
			assertErrors, valueErrors);
		if (assertErrors == 0 && valueErrors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		#(WatchdogCycles * ClockPeriod);
		$display("timeout: sequence did not finish within %0d cycles", WatchdogCycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: list.f
hdl/SdramPkg.sv
hdl/CtrlPkg.sv
hdl/DownTimer.sv
hdl/InitRefreshSequencer.sv
hdl/SdramInitRefreshCtrl.sv
sim/SdramCtrl_asserts.sv
sim/TbSdramCtrl.sv

// File: Makefile
# Verilator build and run for the SDRAM init/refresh controller testbench

VERILATOR := verilator
TOP       := TbSdramCtrl
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := NO ERRORS
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ps
RUNFLAGS  := +verilator+error+limit+1000

SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
